/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

        localparam int xlen = 32;
        localparam int regAddrWidth = 5;
        localparam int shamtWidth = 5;

        // Major opcodes, instWord[6:0]
        localparam logic [6:0] opLui    = 7'b0110111;
        localparam logic [6:0] opAuipc  = 7'b0010111;
        localparam logic [6:0] opJal    = 7'b1101111;
        localparam logic [6:0] opJalr   = 7'b1100111;
        localparam logic [6:0] opBranch = 7'b1100011;
        localparam logic [6:0] opLoad   = 7'b0000011;
        localparam logic [6:0] opStore  = 7'b0100011;
        localparam logic [6:0] opImm    = 7'b0010011;
        localparam logic [6:0] opReg    = 7'b0110011;

        localparam logic [2:0] f3Add  = 3'b000;  // Also jalr
        localparam logic [2:0] f3Sll  = 3'b001;
        localparam logic [2:0] f3Word = 3'b010;  // lw and sw only
        localparam logic [2:0] f3Sr   = 3'b101;  // srl or sra by bit 30
        localparam logic [6:0] funct7Base = 7'b0000000;
        localparam logic [6:0] funct7Alt  = 7'b0100000;

        // Encoded as {inst[30], funct3}
        typedef enum logic [3:0] {
                aluAdd  = 4'b0000,
                aluSub  = 4'b1000,
                aluSll  = 4'b0001,
                aluSlt  = 4'b0010,
                aluSltu = 4'b0011,
                aluXor  = 4'b0100,
                aluSrl  = 4'b0101,
                aluSra  = 4'b1101,
                aluOr   = 4'b0110,
                aluAnd  = 4'b0111
        } aluOp_t;

        typedef enum logic [3:0] {
                clsAluReg,
                clsAluImm,
                clsLui,
                clsAuipc,
                clsJal,
                clsJalr,
                clsBranch,
                clsLoad,
                clsStore,
                clsIllegal
        } instClass_t;

        typedef struct packed {
                instClass_t instClass;
                aluOp_t aluOp;
                logic [2:0] funct3;
                logic [regAddrWidth-1:0] rs1;
                logic [regAddrWidth-1:0] rs2;
                logic [regAddrWidth-1:0] rd;
                logic [xlen-1:0] imm;
                logic writesReg;
        } decodedInst_t;

        typedef struct packed {
                logic [xlen-1:0] aluResult;
                logic [xlen-1:0] nextPc;
                logic [xlen-1:0] linkValue;  // pc + 4
                logic [xlen-1:0] storeData;
        } execResult_t;

        typedef struct packed {
                logic [xlen-1:0] address;
                logic [xlen-1:0] writeData;
                logic read;
                logic write;
        } memReq_t;

endpackage

`default_nettype wire

/* logic/instDecode.sv */
`default_nettype none

module instDecode
(
        input  wire [cpuPkg::xlen-1:0] instWord,
        output cpuPkg::decodedInst_t decoded
);
        import cpuPkg::*;

        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic altLegal;  // funct7 allowed to carry bit 30
        logic [xlen-1:0] immI, immS, immB, immU, immJ;

        assign opcode = instWord[6:0];
        assign funct3 = instWord[14:12];
        assign funct7 = instWord[31:25];
        assign altLegal = funct7 == funct7Base || funct7 == funct7Alt;

        // Immediate formats, all sign extended from bit 31
        assign immI = {{20{instWord[31]}}, instWord[31:20]};
        assign immS = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
        assign immB = {{19{instWord[31]}}, instWord[31], instWord[7], instWord[30:25],
                       instWord[11:8], 1'b0};
        assign immU = {instWord[31:12], 12'b0};
        assign immJ = {{11{instWord[31]}}, instWord[31], instWord[19:12], instWord[20],
                       instWord[30:21], 1'b0};

        always_comb
        begin
                decoded.instClass = clsIllegal;
                decoded.aluOp = aluAdd;
                decoded.funct3 = funct3;
                decoded.rs1 = instWord[19:15];
                decoded.rs2 = instWord[24:20];
                decoded.rd = instWord[11:7];
                decoded.imm = immI;
                case (opcode)
                opLui:
                begin
                        decoded.instClass = clsLui;
                        decoded.imm = immU;
                end
                opAuipc:
                begin
                        decoded.instClass = clsAuipc;
                        decoded.imm = immU;
                end
                opJal:
                begin
                        decoded.instClass = clsJal;
                        decoded.imm = immJ;
                end
                opJalr:
                        if (funct3 == f3Add)
                                decoded.instClass = clsJalr;
                opBranch:
                begin
                        decoded.imm = immB;
                        if (funct3[2:1] != 2'b01)  // 010 and 011 unused
                                decoded.instClass = clsBranch;
                end
                opLoad:
                        if (funct3 == f3Word)
                                decoded.instClass = clsLoad;
                opStore:
                begin
                        decoded.imm = immS;
                        if (funct3 == f3Word)
                                decoded.instClass = clsStore;
                end
                opImm:
                begin
                        // Only shifts look at funct7
                        if ((funct3 != f3Sll || funct7 == funct7Base) && (funct3 != f3Sr || altLegal))
                        begin
                                decoded.instClass = clsAluImm;
                                decoded.aluOp = aluOp_t'({instWord[30] && funct3 == f3Sr, funct3});
                        end
                end
                opReg:
                begin
                        if (funct7 == funct7Base || (funct7 == funct7Alt && (funct3 == f3Add ||
                            funct3 == f3Sr)))
                        begin
                                decoded.instClass = clsAluReg;
                                decoded.aluOp = aluOp_t'({instWord[30], funct3});
                        end
                end
                default:
                        decoded.instClass = clsIllegal;
                endcase
                decoded.writesReg = decoded.instClass != clsBranch &&
                                    decoded.instClass != clsStore &&
                                    decoded.instClass != clsIllegal;
        end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

module regFile
(
        input  wire clk,
        input  wire rst,
        input  wire [cpuPkg::regAddrWidth-1:0] rs1,
        input  wire [cpuPkg::regAddrWidth-1:0] rs2,
        input  wire [cpuPkg::regAddrWidth-1:0] rd,
        input  wire writeEnable,
        input  wire [cpuPkg::xlen-1:0] writeData,
        output logic [cpuPkg::xlen-1:0] rs1Data,
        output logic [cpuPkg::xlen-1:0] rs2Data
);
        import cpuPkg::*;

        logic [xlen-1:0] regs [2**regAddrWidth];

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        for (int i = 0; i < 2**regAddrWidth; i++)
                                regs[i] <= '0;
                end
                else if (writeEnable && rd != '0)  // x0 stays zero
                        regs[rd] <= writeData;
        end

        // Asynchronous read ports
        assign rs1Data = regs[rs1];
        assign rs2Data = regs[rs2];

endmodule

`default_nettype wire

/* logic/execUnit.sv */
`default_nettype none

module execUnit
(
        input  wire cpuPkg::decodedInst_t decoded,
        input  wire [cpuPkg::xlen-1:0] pc,
        input  wire [cpuPkg::xlen-1:0] rs1Data,
        input  wire [cpuPkg::xlen-1:0] rs2Data,
        output cpuPkg::execResult_t exec
);
        import cpuPkg::*;

        logic [xlen-1:0] opA, opB;
        logic [xlen-1:0] aluOut;
        logic [shamtWidth-1:0] shamt;
        logic isJump;
        logic eq, lt, ltu;
        logic cond, taken;

        assign opA = (decoded.instClass == clsAuipc || decoded.instClass == clsJal) ? pc : rs1Data;
        assign opB = (decoded.instClass == clsAluReg || decoded.instClass == clsBranch) ?
                     rs2Data : decoded.imm;
        assign shamt = opB[shamtWidth-1:0];

        // Shared by slt and the branches
        assign eq = opA == opB;
        assign lt = $signed(opA) < $signed(opB);
        assign ltu = opA < opB;

        always_comb
        begin
                case (decoded.aluOp)
                aluAdd:  aluOut = opA + opB;
                aluSub:  aluOut = opA - opB;
                aluSll:  aluOut = opA << shamt;
                aluSlt:  aluOut = {{(xlen-1){1'b0}}, lt};
                aluSltu: aluOut = {{(xlen-1){1'b0}}, ltu};
                aluXor:  aluOut = opA ^ opB;
                aluSrl:  aluOut = opA >> shamt;
                aluSra:  aluOut = $signed(opA) >>> shamt;
                aluOr:   aluOut = opA | opB;
                aluAnd:  aluOut = opA & opB;
                default: aluOut = opA + opB;
                endcase
        end

        // funct3[2:1] picks the compare, funct3[0] inverts it
        always_comb
        begin
                case (decoded.funct3[2:1])
                2'b00:   cond = eq;
                2'b10:   cond = lt;
                default: cond = ltu;
                endcase
        end

        assign taken = decoded.instClass == clsBranch && (cond ^ decoded.funct3[0]);
        assign isJump = decoded.instClass == clsJal || decoded.instClass == clsJalr;

        always_comb
        begin
                exec.aluResult = aluOut;
                exec.linkValue = pc + xlen'(4);
                exec.storeData = rs2Data;
                if (isJump)
                        exec.nextPc = {aluOut[xlen-1:1], 1'b0};
                else if (taken)
                        exec.nextPc = pc + decoded.imm;
                else
                        exec.nextPc = exec.linkValue;  // Also illegal ops
        end

endmodule

`default_nettype wire

/* logic/resultSelect.sv */
`default_nettype none

module resultSelect
(
        input  wire clk,
        input  wire rst,
        input  wire [cpuPkg::xlen-1:0] readData,
        input  wire readDataAck,
        input  wire readDataValid,
        input  wire cpuPkg::decodedInst_t decoded,
        input  wire cpuPkg::execResult_t exec,
        output logic [cpuPkg::xlen-1:0] writeData
);
        import cpuPkg::*;

        logic [xlen-1:0] loadWord;

        always_ff @(posedge clk)
        begin
                if (rst)
                        loadWord <= '0;
                else if (readDataValid && readDataAck)  // Response accepted
                        loadWord <= readData;
        end

        always_comb
        begin
                case (decoded.instClass)
                clsLoad:         writeData = loadWord;
                clsJal, clsJalr: writeData = exec.linkValue;
                clsLui:          writeData = decoded.imm;
                default:         writeData = exec.aluResult;
                endcase
        end

endmodule

`default_nettype wire

/* logic/cpuControl.sv */
`default_nettype none

module cpuControl
#(
        parameter logic [cpuPkg::xlen-1:0] resetVector = '0
)
(
        input  wire clk,
        input  wire rst,
        input  wire instReqAck,
        input  wire [cpuPkg::xlen-1:0] instruction,
        input  wire instValid,
        input  wire memReqAck,
        input  wire readDataValid,
        input  wire cpuPkg::decodedInst_t decoded,
        input  wire cpuPkg::execResult_t exec,
        output logic [cpuPkg::xlen-1:0] pc,
        output logic [cpuPkg::xlen-1:0] instPc,
        output logic instReqValid,
        output logic instAck,
        output cpuPkg::memReq_t memReq,
        output logic readDataAck,
        output logic [cpuPkg::xlen-1:0] instWord,
        output logic regWrite
);
        import cpuPkg::*;

        typedef enum logic [2:0] {
                stFetch,
                stWaitInst,
                stDecode,
                stExecute,
                stMemory,
                stWaitData,
                stWriteBack
        } state_t;

        state_t state, nextState;
        logic isLoad, isStore;

        assign isLoad = decoded.instClass == clsLoad;
        assign isStore = decoded.instClass == clsStore;

        always_ff @(posedge clk)
        begin
                if (rst)
                        state <= stFetch;
                else
                        state <= nextState;
        end

        always_comb
        begin
                nextState = state;
                case (state)
                stFetch:
                        if (instReqAck)
                                nextState = stWaitInst;
                stWaitInst:
                        if (instValid)
                                nextState = stDecode;
                stDecode:
                        nextState = stExecute;
                stExecute:
                        if (decoded.instClass == clsBranch)
                                nextState = stFetch;
                        else if (isLoad || isStore)
                                nextState = stMemory;
                        else
                                nextState = stWriteBack;
                stMemory:
                        if (memReqAck)
                                nextState = isLoad ? stWaitData : stFetch;
                stWaitData:
                        if (readDataValid)
                                nextState = stWriteBack;
                default:
                        nextState = stFetch;  // writeBack lasts one cycle
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (rst)
                        pc <= resetVector;
                else if (state == stExecute)
                        pc <= exec.nextPc;
        end

        // Instruction register, plus the pc it was fetched from for link and auipc
        always_ff @(posedge clk)
        begin
                if (instValid && instAck)
                begin
                        instWord <= instruction;
                        instPc <= pc;
                end
        end

        assign instReqValid = state == stFetch;
        assign instAck = state == stWaitInst;
        assign readDataAck = state == stWaitData;
        assign regWrite = state == stWriteBack && decoded.writesReg;

        assign memReq = '{address: exec.aluResult,
                          writeData: exec.storeData,
                          read: state == stMemory && isLoad,
                          write: state == stMemory && isStore};

        memReqExclusive: assert property (@(posedge clk) disable iff (rst)
                !(memReq.read && memReq.write));

        // Held unchanged until the memory takes it
        memReqStable: assert property (@(posedge clk) disable iff (rst)
                (memReq.read || memReq.write) && !memReqAck |=> $stable(memReq));

endmodule

`default_nettype wire

/* logic/riscvCore.sv */
`default_nettype none

module riscvCore
#(
        parameter logic [cpuPkg::xlen-1:0] resetVector = '0
)
(
        input  wire clk,
        input  wire rst,

        output logic [cpuPkg::xlen-1:0] pc,
        output logic instReqValid,
        input  wire instReqAck,

        input  wire [cpuPkg::xlen-1:0] instruction,
        input  wire instValid,
        output logic instAck,

        output cpuPkg::memReq_t memReq,
        input  wire memReqAck,

        input  wire [cpuPkg::xlen-1:0] readData,
        input  wire readDataValid,
        output logic readDataAck
);
        import cpuPkg::*;

        decodedInst_t decoded;
        execResult_t exec;
        logic [xlen-1:0] instWord;
        logic [xlen-1:0] instPc;  // pc of the instruction in flight
        logic [xlen-1:0] rs1Data, rs2Data;
        logic [xlen-1:0] writeData;
        logic regWrite;

        cpuControl #(
                .resetVector(resetVector)
        ) u_cpuControl (
                .clk(clk),
                .rst(rst),
                .instReqAck(instReqAck),
                .instruction(instruction),
                .instValid(instValid),
                .memReqAck(memReqAck),
                .readDataValid(readDataValid),
                .decoded(decoded),
                .exec(exec),
                .pc(pc),
                .instPc(instPc),
                .instReqValid(instReqValid),
                .instAck(instAck),
                .memReq(memReq),
                .readDataAck(readDataAck),
                .instWord(instWord),
                .regWrite(regWrite)
        );

        instDecode u_instDecode (
                .instWord(instWord),
                .decoded(decoded)
        );

        regFile u_regFile (
                .clk(clk),
                .rst(rst),
                .rs1(decoded.rs1),
                .rs2(decoded.rs2),
                .rd(decoded.rd),
                .writeEnable(regWrite),
                .writeData(writeData),
                .rs1Data(rs1Data),
                .rs2Data(rs2Data)
        );

        execUnit u_execUnit (
                .decoded(decoded),
                .pc(instPc),
                .rs1Data(rs1Data),
                .rs2Data(rs2Data),
                .exec(exec)
        );

        resultSelect u_resultSelect (
                .clk(clk),
                .rst(rst),
                .readData(readData),
                .readDataAck(readDataAck),
                .readDataValid(readDataValid),
                .decoded(decoded),
                .exec(exec),
                .writeData(writeData)
        );

endmodule

`default_nettype wire

/* bench/riscvCoreTb.sv */
`default_nettype none

module riscvCoreTb;
        timeunit 1ns;
        timeprecision 100ps;
        import cpuPkg::*;

        localparam int traceBase = 64;    // Word index of the trace section
        localparam int arithStores = 5;
        localparam int loadStores = 1;
        localparam logic [31:0] selfLoop = 32'h0000006f;  // jal x0, 0

        logic clk = 1'b0;
        logic rst = 1'b1;
        logic [31:0] pc;
        logic instReqValid, instReqAck;
        logic [31:0] instruction;
        logic instValid, instAck;
        memReq_t memReq;
        logic memReqAck;
        logic [31:0] readData;
        logic readDataValid, readDataAck;

        logic [31:0] inputWords [0:127];
        logic [31:0] mem [0:255];
        int progWords, expectedStores, storesSeen, errorCount, currentTest;
        int testErrors [5];
        string testNames [5] = '{"reset", "arithmetic", "loads", "control flow", "completion"};
        bit loaded, programDone;

        always #10 clk = ~clk;

        riscvCore #(
                .resetVector(32'h0)
        ) u_riscvCore (
                .clk(clk),
                .rst(rst),
                .pc(pc),
                .instReqValid(instReqValid),
                .instReqAck(instReqAck),
                .instruction(instruction),
                .instValid(instValid),
                .instAck(instAck),
                .memReq(memReq),
                .memReqAck(memReqAck),
                .readData(readData),
                .readDataValid(readDataValid),
                .readDataAck(readDataAck)
        );

        // Lands 2 ns after a rising edge
        task automatic stepCycles(input int n);
                repeat (n)
                begin
                        @(posedge clk);
                        #2;
                end
        endtask

        task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                                  input string what);
                if (actual !== expected)
                begin
                        $display("Error at %0t ns: %s, got %08h, expected %08h",
                                 $time, what, actual, expected);
                        errorCount++;
                        testErrors[currentTest]++;
                end
        endtask

        task automatic reportTest(input int idx);
                $display("[%0t ns] test %0d %s: %0d mismatches, %s", $time, idx, testNames[idx],
                         testErrors[idx], testErrors[idx] == 0 ? "ok" : "FAIL");
        endtask

        task automatic serveFetch();
                logic [31:0] addr;
                int d;
                addr = pc;
                d = $urandom % 4;
                stepCycles(1 + d);
                checkValue(pc, addr, "fetch address not held");
                instReqAck = 1'b1;
                stepCycles(1);
                instReqAck = 1'b0;
                d = $urandom % 4;
                stepCycles(d);
                instruction = mem[addr[9:2]];
                instValid = 1'b1;
                while (!instAck)  // Held until the core accepts
                        stepCycles(1);
                stepCycles(1);
                instValid = 1'b0;
                if (mem[addr[9:2]] == selfLoop)
                        programDone = 1'b1;
        endtask

        task automatic recordStore(input logic [31:0] addr, input logic [31:0] data);
                int k;
                k = storesSeen;
                if (k >= expectedStores)
                begin
                        $display("Store number %0d to address %08h is beyond the listed trace",
                                 k, addr);
                        errorCount++;
                        testErrors[4]++;
                end
                else
                begin
                        if (k < arithStores)
                                currentTest = 1;
                        else if (k < arithStores + loadStores)
                                currentTest = 2;
                        else
                                currentTest = 3;
                        checkValue(addr, inputWords[traceBase + 2 + 2 * k], "store address");
                        checkValue(data, inputWords[traceBase + 3 + 2 * k], "store data");
                end
                storesSeen++;
                if (storesSeen == arithStores)
                        reportTest(1);
                else if (storesSeen == arithStores + loadStores)
                        reportTest(2);
                else if (storesSeen == expectedStores)
                        reportTest(3);
        endtask

        task automatic serveStore();
                logic [31:0] addr, data;
                int d;
                addr = memReq.address;
                data = memReq.writeData;
                d = $urandom % 4;
                stepCycles(1 + d);
                memReqAck = 1'b1;
                stepCycles(1);
                memReqAck = 1'b0;
                mem[addr[9:2]] = data;
                recordStore(addr, data);
        endtask

        task automatic serveLoad();
                logic [31:0] addr;
                int d;
                addr = memReq.address;
                d = $urandom % 4;
                stepCycles(1 + d);
                memReqAck = 1'b1;
                stepCycles(1);
                memReqAck = 1'b0;
                d = $urandom % 4;
                stepCycles(d);
                readData = mem[addr[9:2]];
                readDataValid = 1'b1;
                while (!readDataAck)
                        stepCycles(1);
                stepCycles(1);
                readDataValid = 1'b0;
        endtask

        initial
        begin
                instReqAck = 1'b0;
                instruction = '0;
                instValid = 1'b0;
                memReqAck = 1'b0;
                readData = '0;
                readDataValid = 1'b0;
                void'($urandom(37650));
                $readmemh("bench/programInput.txt", inputWords);
                progWords = inputWords[traceBase];
                expectedStores = inputWords[traceBase + 1];
                for (int i = 0; i < 256; i++)
                        mem[i] = 32'ha5a50000 | (i * 4);  // Byte address in the low bits
                for (int i = 0; i < progWords; i++)
                        mem[i] = inputWords[i];
                loaded = 1'b1;

                repeat (16) @(posedge clk);
                #2 rst = 1'b0;
                @(negedge clk);
                currentTest = 0;
                checkValue(memReq.read, 1'b0, "memReq.read after reset");
                checkValue(memReq.write, 1'b0, "memReq.write after reset");
                checkValue(instAck, 1'b0, "instAck after reset");
                checkValue(readDataAck, 1'b0, "readDataAck after reset");
                checkValue(pc, 32'h0, "pc after reset");
                checkValue(instReqValid, 1'b1, "instReqValid after reset");
                reportTest(0);

                // Memory model serves one transaction at a time
                while (!programDone)
                begin
                        @(negedge clk);
                        if (instReqValid)
                                serveFetch();
                        else if (memReq.write)
                                serveStore();
                        else if (memReq.read)
                                serveLoad();
                end

                do
                        @(negedge clk);
                while (!instReqValid);
                currentTest = 4;
                // Self-loop is the last program word
                checkValue(pc, (progWords - 1) * 4, "final self-loop target");
                checkValue(storesSeen, expectedStores, "number of stores");
                reportTest(4);

                $display("Tests: 5, stores: %0d of %0d, errors: %0d",
                         storesSeen, expectedStores, errorCount);
                if (errorCount == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

        // Watchdog sized from the program length
        initial
        begin
                wait (loaded);
                #((40 * progWords + 2000) * 20);
                $display("Timeout: the program did not reach its final loop in time");
                $display("Test failed");
                $finish;
        end

endmodule

`default_nettype wire

/* bench/programInput.txt */
// Words 0 to 59: program, four instruction words per line, starting at address 0
// @40: program length, store count, then one expected store per line as address and data
06400093 ff900113 20000513 002081b3
00352023 40110233 00452223 40115293
00552423 40115333 0020b3b3 00112433
001394b3 00652623 0084c5b3 0f017613
00c5e5b3 01c15693 00d585b3 00b52823
00452703 12370713 00e52a23 00208463
00178793 00108463 04078793 00109463
00178793 00209463 04078793 0020c463
00178793 00114463 04078793 00115463
00178793 0020d463 04078793 00116463
00178793 0020e463 04078793 0020f463
00178793 00117463 04078793 00f52c23
00c0086f 04078793 04078793 00000897
00d88967 04078793 01052e23 03252023
abcde9b7 03352223 02f52423 0000006f
@40
0000003c 0000000b
00000200 0000005d
00000204 ffffff95
00000208 fffffffc
0000020c ffffffff
00000210 00000100
00000214 000000b8
00000218 00000006
0000021c 000000c4
00000220 000000d4
00000224 abcde000
00000228 00000006

/* riscvCore.f */
logic/cpuPkg.sv
logic/instDecode.sv
logic/regFile.sv
logic/execUnit.sv
logic/resultSelect.sv
logic/cpuControl.sv
logic/riscvCore.sv
bench/riscvCoreTb.sv
